//--- vdp_pkg.sv
// Shared numbers and types for the VDP CPU register block
// Only the MSX2 register subset is present, with no command engine and no extended registers
`default_nettype none

package vdp_pkg;

  // ----------------------------------------
  // I/O port numbers and register indices
  // ----------------------------------------
  localparam logic [1:0] PORT_VRAM  = 2'd0;  // 0x98
  localparam logic [1:0] PORT_CTRL  = 2'd1;  // 0x99
  localparam logic [1:0] PORT_PAL   = 2'd2;  // 0x9A
  localparam logic [1:0] PORT_INDIR = 2'd3;  // 0x9B

  localparam logic [5:0] REG_R0  = 6'd0;
  localparam logic [5:0] REG_R1  = 6'd1;
  localparam logic [5:0] REG_R2  = 6'd2;
  localparam logic [5:0] REG_R7  = 6'd7;
  localparam logic [5:0] REG_R8  = 6'd8;
  localparam logic [5:0] REG_R9  = 6'd9;
  localparam logic [5:0] REG_R14 = 6'd14;
  localparam logic [5:0] REG_R15 = 6'd15;
  localparam logic [5:0] REG_R16 = 6'd16;
  localparam logic [5:0] REG_R17 = 6'd17;
  localparam logic [5:0] REG_R19 = 6'd19;
  localparam logic [5:0] REG_R23 = 6'd23;
  localparam logic [5:0] REG_R26 = 6'd26;
  localparam logic [5:0] REG_R27 = 6'd27;

  localparam logic [4:0] VDP_ID = 5'd2;  // V9958 identity in S#1
  localparam int PAL_ENTRIES = 16;

  // ----------------------------------------
  // Shared types
  // ----------------------------------------
  typedef struct packed {
    logic       req;   // One cycle per access
    logic       wrt;
    logic [1:0] port;
    logic [7:0] data;
  } cpu_acc_t;

  // Second byte of a port 1 pair
  typedef union packed {
    struct packed { logic [1:0] code; logic [5:0] idx; } reg_sel;  // Code 1x
    struct packed { logic [1:0] code; logic [5:0] hi;  } addr_hi;  // 01 write, 00 read
  } p1_ctrl_u;

  typedef struct packed {
    logic       stb;
    logic [5:0] idx;
    logic [7:0] data;
  } reg_wr_t;

  typedef struct packed {
    logic        vram_wr;
    logic        vram_rd;
    logic        addr_set;
    logic        addr_rd;   // Address set of read type, qualifies addr_set
    logic        pal_wr;
    logic        st_rd;
    logic        other_rd;  // Read of port 2 or 3
    logic [13:0] addr_lo;
    logic [7:0]  data;
  } port_evt_t;

  typedef struct packed {
    logic [2:0] r;
    logic [2:0] g;
    logic [2:0] b;
  } pal_rgb_t;

  // Power-on colours, octal digits are r g b
  localparam pal_rgb_t PAL_RESET [PAL_ENTRIES] = '{
    9'o000, 9'o000, 9'o161, 9'o373, 9'o117, 9'o237, 9'o511, 9'o267,
    9'o711, 9'o733, 9'o661, 9'o664, 9'o141, 9'o625, 9'o555, 9'o777
  };

  typedef struct packed {
    logic       hsync_int_en, sp_size, sp_zoom, bl_clks, vsync_int_en;
    logic [6:0] name_addr;
    logic [7:0] frame_col;
    logic       sp_off, col0_on, pal_mode, interlace, y_dots;
    logic [7:0] hsync_line;
    logic [7:0] vstart_line;
    logic [5:0] h_scroll_hi;
    logic [2:0] h_scroll_lo;
    logic       disp_on;
  } disp_regs_t;

  typedef enum logic [3:0] {
    TEXT1, TEXT1Q, TEXT2, MULTI, MULTIQ, GRAPHIC1, GRAPHIC2, GRAPHIC3,
    GRAPHIC4, GRAPHIC5, GRAPHIC6, GRAPHIC7, MODE_UNDEF
  } vdp_mode_e;

  typedef struct packed {
    logic [16:0] addr;
    logic [7:0]  data;
    logic        addr_set_req, wr_req, rd_req;  // Toggle requests
  } vram_bus_t;

endpackage

`default_nettype wire

//--- vdp_port_ctrl.sv
// CPU access decode; evt strobes for port 0, 2 and reads are combinational in the request cycle
// Address set and register writes come one cycle later. The CPU must wait for ack between accesses
`default_nettype none

module vdp_port_ctrl import vdp_pkg::*; (
  input  wire            RESET,
  input  wire            CLK21M,
  input  wire cpu_acc_t  cpu,
  output port_evt_t      evt,
  output reg_wr_t        reg_wr
);

  logic        wr_acc, rd_acc;
  p1_ctrl_u    p1;            // Second byte view
  logic        first_byte;    // 1 -> next port 1 write is the first of a pair
  logic [7:0]  p1_latch;      // First byte held here
  logic        addr_set_q, addr_rd_q;
  logic [13:0] addr_lo_q;
  logic        reg_stb;
  logic [5:0]  reg_idx;
  logic [7:0]  reg_data;
  logic [5:0]  r17_idx;       // Indirect register pointer
  logic        r17_inc;       // Auto-increment enable

  assign wr_acc = cpu.req & cpu.wrt;
  assign rd_acc = cpu.req & ~cpu.wrt;
  assign p1     = cpu.data;

  // ----------------------------------------
  // Event broadcast
  // ----------------------------------------
  always_comb begin
    evt.vram_wr  = wr_acc & (cpu.port == PORT_VRAM);
    evt.vram_rd  = rd_acc & (cpu.port == PORT_VRAM);
    evt.pal_wr   = wr_acc & (cpu.port == PORT_PAL);
    evt.st_rd    = rd_acc & (cpu.port == PORT_CTRL);
    evt.other_rd = rd_acc & ((cpu.port == PORT_PAL) | (cpu.port == PORT_INDIR));
    evt.addr_set = addr_set_q;  // Registered, second byte seen last cycle
    evt.addr_rd  = addr_rd_q;
    evt.addr_lo  = addr_lo_q;
    evt.data     = cpu.data;
    reg_wr.stb   = reg_stb;
    reg_wr.idx   = reg_idx;
    reg_wr.data  = reg_data;
  end

  // ----------------------------------------
  // Byte pairing, R17 and write strobes
  // ----------------------------------------
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      first_byte <= 1'b1;
      addr_set_q <= 1'b0;
      addr_rd_q  <= 1'b0;
      reg_stb    <= 1'b0;
      r17_idx    <= 6'd0;
      r17_inc    <= 1'b0;
    end else begin
      addr_set_q <= 1'b0;
      addr_rd_q  <= 1'b0;
      reg_stb    <= 1'b0;
      if (evt.st_rd) first_byte <= 1'b1;     // Status read restarts the pair
      if (wr_acc && cpu.port == PORT_CTRL) begin
        first_byte <= ~first_byte;
        if (!first_byte) begin
          if (p1.reg_sel.code[1]) begin
            reg_stb <= 1'b1;                   // Register select
          end else begin
            addr_set_q <= 1'b1;
            addr_rd_q  <= ~p1.addr_hi.code[0]; // Code 00 prefetches a read
          end
        end
      end
      if (wr_acc && cpu.port == PORT_INDIR) begin
        reg_stb <= (r17_idx != REG_R17);     // R17 is not reachable through itself
        if (r17_inc) r17_idx <= r17_idx + 6'd1;
      end
      if (reg_stb && reg_idx == REG_R17) begin
        r17_idx <= reg_data[5:0];
        r17_inc <= ~reg_data[7];             // Bit 7 set disables increment
      end
    end
  end

  // Payload side
  always_ff @(posedge RESET) begin
    if (wr_acc && cpu.port == PORT_CTRL) begin
      if (first_byte) begin
        p1_latch <= cpu.data;
      end else begin
        reg_idx   <= p1.reg_sel.idx;
        reg_data  <= p1_latch;
        addr_lo_q <= {p1.addr_hi.hi, p1_latch};
      end
    end else if (wr_acc && cpu.port == PORT_INDIR) begin
      reg_idx  <= r17_idx;
      reg_data <= cpu.data;
    end
  end

endmodule

`default_nettype wire

//--- vdp_ctrl_regs.sv
// Display control registers R0-R2, R7-R9, R19, R23, R26, R27
// Mode bits, display enable and coarse h-scroll reach the outputs only while hsync is high
`default_nettype none

module vdp_ctrl_regs import vdp_pkg::*; (
  input  wire           RESET,
  input  wire           CLK21M,
  input  wire reg_wr_t  reg_wr,
  input  wire           hsync,
  output disp_regs_t    disp,
  output vdp_mode_e     mode,
  output logic          sprite_mode2
);

  disp_regs_t dr;                    // Written values, hsync fields still pending here
  logic [3:1] r0_mode, r0_mode_q;    // M5..M3
  logic [1:0] r1_mode, r1_mode_q;    // [1] M1, [0] M2
  logic       disp_on_q;
  logic [5:0] h_scroll_q;
  logic [4:0] mcode;                 // M5..M1

  // ----------------------------------------
  // Register writes
  // ----------------------------------------
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      dr      <= '0;
      r0_mode <= 3'd0;
      r1_mode <= 2'd0;
    end else if (reg_wr.stb) begin
      case (reg_wr.idx)
        REG_R0: begin
          dr.hsync_int_en <= reg_wr.data[4];
          r0_mode         <= reg_wr.data[3:1];
        end
        REG_R1: begin
          dr.sp_zoom      <= reg_wr.data[0];
          dr.sp_size      <= reg_wr.data[1];
          dr.bl_clks      <= reg_wr.data[2];
          r1_mode         <= reg_wr.data[4:3];
          dr.vsync_int_en <= reg_wr.data[5];
          dr.disp_on      <= reg_wr.data[6];
        end
        REG_R2:  dr.name_addr <= reg_wr.data[6:0];
        REG_R7:  dr.frame_col <= reg_wr.data;
        REG_R8: begin
          dr.sp_off  <= reg_wr.data[1];
          dr.col0_on <= reg_wr.data[5];
        end
        REG_R9: begin
          dr.pal_mode  <= reg_wr.data[1];
          dr.interlace <= reg_wr.data[3];
          dr.y_dots    <= reg_wr.data[7];
        end
        REG_R19: dr.hsync_line  <= reg_wr.data;
        REG_R23: dr.vstart_line <= reg_wr.data;
        REG_R26: dr.h_scroll_hi <= reg_wr.data[5:0];
        REG_R27: dr.h_scroll_lo <= reg_wr.data[2:0];
        default: begin
        end
      endcase
    end
  end

  // Shadows follow on hsync
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      r0_mode_q  <= 3'd0;
      r1_mode_q  <= 2'd0;
      disp_on_q  <= 1'b0;
      h_scroll_q <= 6'd0;
    end else if (hsync) begin
      r0_mode_q  <= r0_mode;
      r1_mode_q  <= r1_mode;
      disp_on_q  <= dr.disp_on;
      h_scroll_q <= dr.h_scroll_hi;
    end
  end

  // ----------------------------------------
  // Outputs and mode decode
  // ----------------------------------------
  assign mcode        = {r0_mode_q, r1_mode_q[0], r1_mode_q[1]};
  assign sprite_mode2 = (r1_mode_q == 2'b00) && (r0_mode_q[3] | r0_mode_q[2]);

  always_comb begin
    disp             = dr;
    disp.disp_on     = disp_on_q;
    disp.h_scroll_hi = h_scroll_q;
    case (mcode)
      5'b00000: mode = GRAPHIC1;
      5'b00001: mode = TEXT1;
      5'b00010: mode = MULTI;
      5'b00100: mode = GRAPHIC2;
      5'b00101: mode = TEXT1Q;
      5'b00110: mode = MULTIQ;
      5'b01000: mode = GRAPHIC3;
      5'b01001: mode = TEXT2;
      5'b01100: mode = GRAPHIC4;
      5'b10000: mode = GRAPHIC5;
      5'b10100: mode = GRAPHIC6;
      5'b11100: mode = GRAPHIC7;
      default:  mode = MODE_UNDEF;   // Mixed M bits
    endcase
  end

endmodule

`default_nettype wire

//--- vdp_vram_port.sv
// VRAM address and toggle requests toward the arbiter; a request is pending while req != ack
// The arbiter sees each new request only as a toggle, so repeated requests must be spaced by the CPU
`default_nettype none

module vdp_vram_port import vdp_pkg::*; (
  input  wire             RESET,
  input  wire             CLK21M,
  input  wire port_evt_t  evt,
  input  wire reg_wr_t    reg_wr,
  input  wire             addr_set_ack,
  input  wire             wr_ack,
  input  wire             rd_ack,
  output vram_bus_t       vram
);

  logic        r14_pend;   // R14 written last cycle, address set follows
  logic [16:0] addr;
  logic [7:0]  wdata;
  logic        set_req, wr_req, rd_req;

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      r14_pend <= 1'b0;
      addr     <= 17'd0;
      set_req  <= 1'b0;
      wr_req   <= 1'b0;
      rd_req   <= 1'b0;
    end else begin
      r14_pend <= reg_wr.stb && (reg_wr.idx == REG_R14);
      if (r14_pend) addr[16:14] <= reg_wr.data[2:0];   // Bank bits, payload held by ctrl
      if (evt.addr_set) addr[13:0] <= evt.addr_lo;
      if (evt.addr_set || r14_pend) set_req <= ~addr_set_ack;
      if (evt.vram_wr) wr_req <= ~wr_ack;
      if (evt.vram_rd || (evt.addr_set && evt.addr_rd)) rd_req <= ~rd_ack;  // Read prefetch
    end
  end

  always_ff @(posedge RESET) begin
    if (evt.vram_wr) wdata <= evt.data;
  end

  assign vram = '{addr: addr, data: wdata, addr_set_req: set_req, wr_req: wr_req,
                  rd_req: rd_req};

endmodule

`default_nettype wire

//--- vdp_palette.sv
// 16-entry palette, 3 bits per colour, two bytes per entry through port 2
// An entry is written one cycle after its green byte; the read port is registered
`default_nettype none

module vdp_palette import vdp_pkg::*; (
  input  wire             RESET,
  input  wire             CLK21M,
  input  wire port_evt_t  evt,
  input  wire reg_wr_t    reg_wr,
  input  wire [3:0]       pal_addr,
  output pal_rgb_t        pal_data
);

  pal_rgb_t   mem [PAL_ENTRIES];
  logic       green_next;   // 0 -> red/blue byte, 1 -> green byte
  logic [3:0] pal_idx;      // R16
  logic       wr_pend;
  logic [3:0] wr_num;
  pal_rgb_t   wr_rgb;

  // ----------------------------------------
  // Byte sequencing and memory write
  // ----------------------------------------
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      green_next <= 1'b0;
      pal_idx    <= 4'd0;
      wr_pend    <= 1'b0;
      for (int i = 0; i < PAL_ENTRIES; i++) mem[i] <= PAL_RESET[i];
    end else begin
      wr_pend <= evt.pal_wr & green_next;
      if (wr_pend) mem[wr_num] <= wr_rgb;
      if (reg_wr.stb && reg_wr.idx == REG_R16) begin
        pal_idx    <= reg_wr.data[3:0];
        green_next <= 1'b0;                // New start, red/blue first
      end else if (evt.pal_wr) begin
        green_next <= ~green_next;
        if (green_next) pal_idx <= pal_idx + 4'd1;  // Wraps at 16
      end
    end
  end

  always_ff @(posedge RESET) begin
    if (evt.pal_wr && !green_next) begin
      wr_rgb.r <= evt.data[6:4];
      wr_rgb.b <= evt.data[2:0];
    end
    if (evt.pal_wr && green_next) begin
      wr_rgb.g <= evt.data[2:0];
      wr_num   <= pal_idx;
    end
    pal_data <= mem[pal_addr];   // Display read port
  end

endmodule

`default_nettype wire

//--- vdp_status_read.sv
// CPU read data and interrupt clear strobes
// S#0 to S#2 only; other status numbers and ports 2, 3 read as all ones
`default_nettype none

module vdp_status_read import vdp_pkg::*; (
  input  wire             RESET,
  input  wire             CLK21M,
  input  wire port_evt_t  evt,
  input  wire reg_wr_t    reg_wr,
  input  wire [7:0]       vram_rd_data,
  input  wire             vint_pending,
  input  wire             hint_pending,
  input  wire [6:0]       sprite_flags,
  input  wire             vd,
  input  wire             hd,
  input  wire             field,
  output logic [7:0]      dbi,
  output logic            clr_vsync_int,
  output logic            clr_hsync_int
);

  logic [3:0] r15;   // Status register number

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      r15           <= 4'd0;
      clr_vsync_int <= 1'b0;
      clr_hsync_int <= 1'b0;
    end else begin
      if (reg_wr.stb && reg_wr.idx == REG_R15) r15 <= reg_wr.data[3:0];
      clr_vsync_int <= evt.st_rd && (r15 == 4'd0);
      clr_hsync_int <= (evt.st_rd && (r15 == 4'd1))
                    || (reg_wr.stb && reg_wr.idx == REG_R19)              // New line number
                    || (reg_wr.stb && reg_wr.idx == REG_R0 && reg_wr.data[4]);
    end
  end

  // ----------------------------------------
  // Read data, held until the next read
  // ----------------------------------------
  always_ff @(posedge RESET) begin
    if (evt.vram_rd) begin
      dbi <= vram_rd_data;
    end else if (evt.st_rd) begin
      case (r15)
        4'd0:    dbi <= {vint_pending, sprite_flags};
        4'd1:    dbi <= {2'b00, VDP_ID, hint_pending};
        4'd2:    dbi <= {1'b0, vd, hd, 1'b0, 2'b11, field, 1'b0};  // No command engine bits
        default: dbi <= 8'hff;
      endcase
    end else if (evt.other_rd) begin
      dbi <= 8'hff;
    end
  end

endmodule

`default_nettype wire

//--- vdp_regs_top.sv
// VDP CPU register block; RESET is the clock and CLK21M the asynchronous reset
// The CPU holds off its next access until ack, there is no other flow control
`default_nettype none

module vdp_regs_top import vdp_pkg::*; (
  input  wire            RESET,
  input  wire            CLK21M,
  input  wire cpu_acc_t  cpu,
  input  wire [7:0]      vram_rd_data,
  input  wire            addr_set_ack,
  input  wire            wr_ack,
  input  wire            rd_ack,
  input  wire            hsync,
  input  wire            vint_pending,
  input  wire            hint_pending,
  input  wire [6:0]      sprite_flags,
  input  wire            vd,
  input  wire            hd,
  input  wire            field,
  input  wire [3:0]      pal_addr,
  output logic           ack,
  output logic [7:0]     dbi,
  output vram_bus_t      vram,
  output logic           clr_vsync_int,
  output logic           clr_hsync_int,
  output disp_regs_t     disp,
  output vdp_mode_e      mode,
  output logic           sprite_mode2,
  output pal_rgb_t       pal_data
);

  port_evt_t evt;
  reg_wr_t   reg_wr;

  // CPU acknowledge one cycle after req
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) ack <= 1'b0;
    else        ack <= cpu.req;
  end

  vdp_port_ctrl   u_ctrl   (.RESET, .CLK21M, .cpu, .evt, .reg_wr);
  vdp_ctrl_regs   u_regs   (.RESET, .CLK21M, .reg_wr, .hsync, .disp, .mode, .sprite_mode2);
  vdp_vram_port   u_vram   (.RESET, .CLK21M, .evt, .reg_wr, .addr_set_ack, .wr_ack, .rd_ack,
                            .vram);
  vdp_palette     u_pal    (.RESET, .CLK21M, .evt, .reg_wr, .pal_addr, .pal_data);
  vdp_status_read u_status (.RESET, .CLK21M, .evt, .reg_wr, .vram_rd_data, .vint_pending,
                            .hint_pending, .sprite_flags, .vd, .hd, .field, .dbi,
                            .clr_vsync_int, .clr_hsync_int);

endmodule

`default_nettype wire

//--- vdp_regs_props.sv
// Handshake timing properties for vdp_regs_top, bound into every instance
`default_nettype none

module vdp_regs_props import vdp_pkg::*; (
  input wire            RESET,
  input wire            CLK21M,
  input wire cpu_acc_t  cpu,
  input wire            ack,
  input wire            clr_vsync_int,
  input wire            clr_hsync_int,
  input wire vram_bus_t vram
);

  int fail_cnt = 0;   // Failed assertions so far

  // One ack pulse in the cycle after each req
  a_ack: assert property (@(posedge RESET) disable iff (CLK21M) cpu.req |=> ack ##1 !ack)
    else begin
      $error("ack not a single pulse one cycle after req");
      fail_cnt++;
    end

  a_clr_v: assert property (@(posedge RESET) disable iff (CLK21M)
    clr_vsync_int |=> !clr_vsync_int)
    else begin
      $error("clr_vsync_int longer than one cycle");
      fail_cnt++;
    end
  a_clr_h: assert property (@(posedge RESET) disable iff (CLK21M)
    clr_hsync_int |=> !clr_hsync_int)
    else begin
      $error("clr_hsync_int longer than one cycle");
      fail_cnt++;
    end

  // Write toggle only after a port 0 write
  a_wr_req: assert property (@(posedge RESET) disable iff (CLK21M)
    $changed(vram.wr_req) |-> $past(cpu.req && cpu.wrt && cpu.port == PORT_VRAM))
    else begin
      $error("wr_req toggled without a port 0 write");
      fail_cnt++;
    end

endmodule

bind vdp_regs_top vdp_regs_props u_props (.RESET, .CLK21M, .cpu, .ack, .clr_vsync_int,
                                          .clr_hsync_int, .vram);

`default_nettype wire

//--- tb_vdp_regs.sv
// Testbench for vdp_regs_top with seeded random CPU traffic and a reference model
// RESET is the clock, CLK21M the reset; VRAM acks echo req after 1 to 4 cycles
`default_nettype none

module tb_vdp_regs import vdp_pkg::*; ();

  localparam int NOPS  = 250;
  localparam int LIMIT = 40 * (2 * NOPS + 16) + 200;  // Two accesses per op at most

  logic RESET, CLK21M, addr_set_ack, wr_ack, rd_ack, hsync, vint_pending, hint_pending;
  logic vd, hd, field, ack, clr_vsync_int, clr_hsync_int, sprite_mode2;
  logic [6:0] sprite_flags;
  logic [7:0] vram_rd_data, dbi;
  logic [3:0] pal_addr;
  cpu_acc_t cpu;
  vram_bus_t vram;
  disp_regs_t disp;
  vdp_mode_e mode;
  pal_rgb_t pal_data;

  // Model state
  disp_regs_t m_disp;                    // disp_on, h_scroll_hi hold the pending values
  logic [2:0] m_m543, sh_m543;           // M5..M3
  logic m_m1, m_m2, sh_m1, sh_m2, sh_don, p_first, p_phase, m_inc;
  logic [5:0] sh_hs, m_r17;
  logic [7:0] p_latch, m_wdata;
  logic [3:0] m_r15, m_pidx;
  logic [2:0] m_pr, m_pb, exp_req;       // exp_req is set, wr, rd parity
  logic [16:0] m_addr;
  pal_rgb_t m_pal [PAL_ENTRIES];
  int cyc = 0;
  int dly [3] = '{0, 0, 0};
  logic [5:0] kept [14] = '{0, 1, 2, 7, 8, 9, 14, 15, 16, 17, 19, 23, 26, 27};

  vdp_regs_top dut0 (.*);

  always #4 RESET = ~RESET;

  // ----------------------------------------
  // Cycle limit, hsync, VRAM responder
  // ----------------------------------------
  always @(posedge RESET) begin
    cyc++;
    if (cyc > LIMIT) begin
      $display("Timeout, run did not finish within %0d cycles", LIMIT);
      $display("RESULT: FAIL");
      $fatal(1);
    end
    #1 hsync = (cyc % 16 == 0);          // One cycle in every 16
    if (dut0.u_props.fail_cnt != 0) begin
      $display("Handshake assertion in vdp_regs_props failed");
      $display("RESULT: FAIL");
      $fatal(1);
    end
  end

  always @(posedge RESET) begin
    logic [2:0] rq, ak;
    rq = {vram.addr_set_req, vram.wr_req, vram.rd_req};
    ak = {addr_set_ack, wr_ack, rd_ack};
    #1;
    for (int i = 0; i < 3; i++) begin
      if (rq[i] != ak[i]) begin
        if (dly[i] == 0) dly[i] = 1 + $urandom % 4;
        dly[i]--;
        if (dly[i] == 0) ak[i] = rq[i];  // Arbiter done
      end
    end
    {addr_set_ack, wr_ack, rd_ack} = ak;
  end

  // Shadow fields of the model follow the pending ones while hsync is high
  always @(posedge RESET) begin
    if (!CLK21M && hsync) begin
      sh_m543 <= m_m543;
      sh_m1   <= m_m1;
      sh_m2   <= m_m2;
      sh_don  <= m_disp.disp_on;
      sh_hs   <= m_disp.h_scroll_hi;
    end
  end

  // ----------------------------------------
  // Model helpers and checks
  // ----------------------------------------
  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (exp === got) else begin
      $display("Fail %s exp %0h got %0h", name, exp, got);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  function automatic vdp_mode_e decode(input logic [4:0] m);  // M5 M4 M3 M2 M1
    case (m)
      5'b00000: return GRAPHIC1;
      5'b00001: return TEXT1;
      5'b00010: return MULTI;
      5'b00100: return GRAPHIC2;
      5'b00101: return TEXT1Q;
      5'b00110: return MULTIQ;
      5'b01000: return GRAPHIC3;
      5'b01001: return TEXT2;
      5'b01100: return GRAPHIC4;
      5'b10000: return GRAPHIC5;
      5'b10100: return GRAPHIC6;
      5'b11100: return GRAPHIC7;
      default:  return MODE_UNDEF;
    endcase
  endfunction

  task automatic apply_reg(input logic [5:0] idx, input logic [7:0] d);
    case (idx)
      0: {m_disp.hsync_int_en, m_m543} = d[4:1];
      1: begin
        {m_disp.bl_clks, m_disp.sp_size, m_disp.sp_zoom} = d[2:0];
        {m_m1, m_m2} = d[4:3];
        {m_disp.disp_on, m_disp.vsync_int_en} = d[6:5];
      end
      2: m_disp.name_addr = d[6:0];
      7: m_disp.frame_col = d;
      8: {m_disp.col0_on, m_disp.sp_off} = {d[5], d[1]};
      9: {m_disp.y_dots, m_disp.interlace, m_disp.pal_mode} = {d[7], d[3], d[1]};
      14: begin
        m_addr[16:14] = d[2:0];
        exp_req[2] ^= 1'b1;              // Bank write also sets the address
      end
      15: m_r15 = d[3:0];
      16: {m_pidx, p_phase} = {d[3:0], 1'b0};
      17: {m_inc, m_r17} = {~d[7], d[5:0]};
      19: m_disp.hsync_line = d;
      23: m_disp.vstart_line = d;
      26: m_disp.h_scroll_hi = d[5:0];
      27: m_disp.h_scroll_lo = d[2:0];
      default: ;
    endcase
  endtask

  // One CPU access, then checks in cycles n+1, n+2 and n+3
  task automatic access(input logic wrt, input logic [1:0] port, input logic [7:0] d);
    logic have_wr, exp_cv, exp_ch_rd, exp_ch_wr;
    logic [5:0] w_idx;
    logic [7:0] w_data, exp_dbi;
    disp_regs_t e;
    have_wr = 0;
    w_idx = 0;
    w_data = 0;
    while ({vram.addr_set_req, vram.wr_req, vram.rd_req} != {addr_set_ack, wr_ack, rd_ack})
      @(posedge RESET);
    @(posedge RESET);
    #1;
    {vint_pending, hint_pending, vd, hd, field} = $urandom;
    sprite_flags = $urandom;
    vram_rd_data = $urandom;
    exp_dbi = 8'hff;
    exp_cv = !wrt && port == 1 && m_r15 == 0;
    exp_ch_rd = !wrt && port == 1 && m_r15 == 1;
    if (!wrt && port == 0) exp_dbi = vram_rd_data;
    if (!wrt && port == 1) begin
      p_first = 1;
      case (m_r15)
        0: exp_dbi = {vint_pending, sprite_flags};
        1: exp_dbi = {2'b00, VDP_ID, hint_pending};
        2: exp_dbi = {1'b0, vd, hd, 1'b0, 1'b1, 1'b1, field, 1'b0};
        default: exp_dbi = 8'hff;
      endcase
    end
    if (!wrt && port == 0) exp_req[0] ^= 1'b1;
    if (wrt && port == 0) {exp_req[1], m_wdata} = {~exp_req[1], d};
    if (wrt && port == 1) begin
      if (p_first) begin
        {p_first, p_latch} = {1'b0, d};
      end else begin
        p_first = 1;
        if (d[7]) begin
          {have_wr, w_idx, w_data} = {1'b1, d[5:0], p_latch};
        end else begin
          m_addr[13:0] = {d[5:0], p_latch};
          exp_req[2] ^= 1'b1;
          if (!d[6]) exp_req[0] ^= 1'b1;  // Read prefetch
        end
      end
    end
    if (wrt && port == 2) begin
      if (!p_phase) begin
        {m_pr, m_pb} = {d[6:4], d[2:0]};
      end else begin
        m_pal[m_pidx] = {m_pr, d[2:0], m_pb};
        m_pidx++;
      end
      p_phase = ~p_phase;
    end
    if (wrt && port == 3) begin
      if (m_r17 != 17) {have_wr, w_idx, w_data} = {1'b1, m_r17, d};
      if (m_inc) m_r17++;
    end
    exp_ch_wr = have_wr && (w_idx == 19 || (w_idx == 0 && w_data[4]));
    cpu = '{req: 1'b1, wrt: wrt, port: port, data: d};
    @(posedge RESET);
    #1;
    cpu.req = 0;                         // Request lasts one cycle
    while (!ack) begin
      @(posedge RESET);
      #1;
    end
    if (!wrt) check("dbi", exp_dbi, dbi);
    check("clr_vsync_rd", exp_cv, clr_vsync_int);
    check("clr_hsync_rd", exp_ch_rd, clr_hsync_int);
    @(posedge RESET);
    #1;
    if (have_wr) apply_reg(w_idx, w_data);  // Registers took the write at this edge
    check("ack_len", 0, ack);
    check("clr_vsync_wr", 0, clr_vsync_int);
    check("clr_hsync_wr", exp_ch_wr, clr_hsync_int);
    @(posedge RESET);
    #1;
    e = m_disp;
    e.disp_on = sh_don;
    e.h_scroll_hi = sh_hs;
    check("disp", e, disp);
    check("mode", decode({sh_m543, sh_m2, sh_m1}), mode);
    check("sprite_mode2", !sh_m1 && !sh_m2 && (sh_m543[2] | sh_m543[1]), sprite_mode2);
    check("vram_addr", m_addr, vram.addr);
    check("vram_req", exp_req, {vram.addr_set_req, vram.wr_req, vram.rd_req});
    if (wrt && port == 0) check("vram_data", m_wdata, vram.data);
  endtask

  task automatic check_palette();
    for (int i = 0; i < PAL_ENTRIES; i++) begin
      @(posedge RESET);
      #1 pal_addr = i;
      @(posedge RESET);
      #1 check("pal_data", m_pal[i], pal_data);
    end
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    logic [7:0] d;
    void'($urandom(32'h41bd_1316));
    {RESET, CLK21M, hsync, addr_set_ack, wr_ack, rd_ack} = 6'b010000;
    {vint_pending, hint_pending, vd, hd, field, sprite_flags} = '0;
    {vram_rd_data, pal_addr} = '0;
    cpu = '0;
    {m_disp, m_m543, m_m1, m_m2, sh_m543, sh_m1, sh_m2, sh_don, sh_hs} = '0;
    {m_r17, m_inc, m_r15, m_pidx, p_phase, m_addr, exp_req, m_wdata} = '0;
    p_first = 1;
    foreach (m_pal[i]) m_pal[i] = PAL_RESET[i];
    repeat (2) @(posedge RESET);
    #1 CLK21M = 0;
    check_palette();
    for (int n = 0; n < NOPS; n++) begin
      d = $urandom;
      case ($urandom % 8)
        0: begin                            // Register write through port 1
          access(1, 1, d);
          access(1, 1, {2'b10, kept[$urandom % 14]});
        end
        1: access(1, 3, d);
        2: begin                            // Address set, read or write type
          access(1, 1, d);
          access(1, 1, {1'b0, 1'($urandom), 6'($urandom)});
        end
        3: access(1, 0, d);
        4: access(0, 0, 8'h00);
        5: access(1, 2, d);
        6: access(0, 1, 8'h00);
        default: access(0, 2'(2 + $urandom % 2), 8'h00);
      endcase
      if (n % 50 == 49) check_palette();
    end
    check_palette();
    if (dut0.u_props.fail_cnt == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("Handshake assertion in vdp_regs_props failed");
      $display("RESULT: FAIL");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
vdp_pkg.sv
vdp_port_ctrl.sv
vdp_ctrl_regs.sv
vdp_vram_port.sv
vdp_palette.sv
vdp_status_read.sv
vdp_regs_top.sv
vdp_regs_props.sv
tb_vdp_regs.sv
